//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// line address on both buses, tag above index
`define CACHE_ADDR_W  12
`define CACHE_TAG_W   9
`define CACHE_INDEX_W 3

// number of sets, two ways each
`define CACHE_SETS    8

// one line is 16 bytes
`define CACHE_LINE_W  128
`define CACHE_SEL_W   16

`endif

//--- design/cache_types_pkg.sv
`include "cache_params.svh"

package cache_types_pkg;

    // full line as moved on either bus
    typedef logic [`CACHE_LINE_W-1:0] cache_word;

    typedef logic [`CACHE_TAG_W-1:0] cache_tag;

    typedef logic [`CACHE_INDEX_W-1:0] cache_index;

    // byte enables, bit i covers byte i of the line
    typedef logic [`CACHE_SEL_W-1:0] cache_sel;

    // flat view on the buses, split view for lookup
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] flat;
        struct packed {
            cache_tag   tag;
            cache_index index;
        } fields;
    } cache_addr_u;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESPOND,
        ST_WRITEBACK,
        ST_FETCH
    } ctrl_state_e;

endpackage : cache_types_pkg

//--- design/cache_ctrl_if.sv
interface cache_ctrl_if (
    input logic clk,
    input logic rst_n
);

    // controller to datapath
    logic way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;
    cache_types_pkg::ctrl_state_e state;

    // datapath to controller
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    modport control (
        output way_sel,
        output data_source_sel,
        output tag_bypass_sel,
        output load,
        output load_lru,
        output state,
        input  hit_0,
        input  hit_1,
        input  dirty,
        input  lru
    );

    modport datapath (
        input  way_sel,
        input  data_source_sel,
        input  tag_bypass_sel,
        input  load,
        input  load_lru,
        output hit_0,
        output hit_1,
        output dirty,
        output lru
    );

    // a processor write only lands in idle, on the way that actually hits
    cpu_write_on_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (load && !data_source_sel) |->
            (state == cache_types_pkg::ST_IDLE) && (way_sel ? hit_1 : hit_0)
    );

endinterface : cache_ctrl_if

//--- design/cache_way.sv
`include "cache_params.svh"

module cache_way (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load,
    input  logic                         load_type,
    input  cache_types_pkg::cache_sel    byte_sel,
    input  cache_types_pkg::cache_addr_u addr,
    input  cache_types_pkg::cache_word   data_in,
    output cache_types_pkg::cache_tag    tag_out,
    output cache_types_pkg::cache_word   data_out,
    output logic                         dirty_out,
    output logic                         hit_out
);

    cache_types_pkg::cache_word  data_arr [`CACHE_SETS];
    cache_types_pkg::cache_tag   tag_arr [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]      valid_q;
    logic [`CACHE_SETS-1:0]      dirty_q;
    cache_types_pkg::cache_index index;
    cache_types_pkg::cache_word  merged;

    assign index = addr.fields.index;

    // byte merge of new data over the stored line
    // a fill arrives with every mask bit set
    always_comb begin
        merged = data_arr[index];
        for (int i = 0; i < `CACHE_SEL_W; i++) begin
            if (byte_sel[i]) begin
                merged[8*i +: 8] = data_in[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_arr[index] <= merged;
            // tag only changes on a fill from memory
            if (load_type) begin
                tag_arr[index] <= addr.fields.tag;
            end
        end
    end

    // load_type 1 is a memory fill, 0 a processor write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (load) begin
            if (load_type) begin
                valid_q[index] <= 1'b1;
            end
            dirty_q[index] <= ~load_type;
        end
    end

    // lookup is combinational on the index
    assign tag_out   = tag_arr[index];
    assign data_out  = data_arr[index];
    assign dirty_out = dirty_q[index];
    assign hit_out   = valid_q[index] && (tag_arr[index] == addr.fields.tag);

    load_index_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !$isunknown(index)
    );

endmodule : cache_way

//--- design/cache_l1_datapath.sv
`include "cache_params.svh"

module cache_l1_datapath (
    input  logic                         clk,
    input  logic                         rst_n,
    cache_ctrl_if.datapath               ctrl,
    input  cache_types_pkg::cache_addr_u cpu_adr,
    input  cache_types_pkg::cache_sel    cpu_sel,
    input  cache_types_pkg::cache_word   cpu_dat_m,
    input  cache_types_pkg::cache_word   mem_dat_s,
    output cache_types_pkg::cache_word   cpu_dat_s,
    output cache_types_pkg::cache_addr_u mem_adr,
    output cache_types_pkg::cache_word   mem_dat_m
);

    cache_types_pkg::cache_word src_data;
    cache_types_pkg::cache_sel  src_sel;
    cache_types_pkg::cache_word way_data [2];
    cache_types_pkg::cache_tag  way_tag [2];
    cache_types_pkg::cache_tag  sel_tag;
    logic [1:0]                 way_load;
    logic [1:0]                 way_dirty;
    logic [1:0]                 way_hit;
    logic [`CACHE_SETS-1:0]     lru_q;

    // write source: processor data with its mask, or a full line from memory
    assign src_data = ctrl.data_source_sel ? mem_dat_s : cpu_dat_m;
    assign src_sel  = ctrl.data_source_sel ? {`CACHE_SEL_W{1'b1}} : cpu_sel;

    // load goes only to the selected way
    assign way_load[0] = ctrl.load & ~ctrl.way_sel;
    assign way_load[1] = ctrl.load & ctrl.way_sel;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way u_way (
            .clk       (clk),
            .rst_n     (rst_n),
            .load      (way_load[w]),
            .load_type (ctrl.data_source_sel),
            .byte_sel  (src_sel),
            .addr      (cpu_adr),
            .data_in   (src_data),
            .tag_out   (way_tag[w]),
            .data_out  (way_data[w]),
            .dirty_out (way_dirty[w]),
            .hit_out   (way_hit[w])
        );
    end

    assign ctrl.hit_0 = way_hit[0];
    assign ctrl.hit_1 = way_hit[1];

    // same line feeds the processor read and the writeback
    assign cpu_dat_s = way_data[ctrl.way_sel];
    assign mem_dat_m = way_data[ctrl.way_sel];
    assign sel_tag   = way_tag[ctrl.way_sel];

    // victim tag for writeback, request tag for fetch
    always_comb begin
        mem_adr.fields.tag   = ctrl.tag_bypass_sel ? cpu_adr.fields.tag : sel_tag;
        mem_adr.fields.index = cpu_adr.fields.index;
    end

    // lru bit names the way to evict next
    assign ctrl.lru   = lru_q[cpu_adr.fields.index];
    assign ctrl.dirty = way_dirty[ctrl.lru];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (ctrl.load_lru) begin
            lru_q[cpu_adr.fields.index] <= ~ctrl.way_sel;
        end
    end

    // a line may live in only one way
    single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.hit_0 && ctrl.hit_1)
    );

endmodule : cache_l1_datapath

//--- design/cache_l1_control.sv
module cache_l1_control (
    input  logic          clk,
    input  logic          rst_n,
    cache_ctrl_if.control ctrl,
    input  logic          cpu_stb,
    input  logic          cpu_we,
    input  logic          mem_ack,
    output logic          cpu_ack,
    output logic          mem_stb,
    output logic          mem_we
);

    cache_types_pkg::ctrl_state_e state_q;
    cache_types_pkg::ctrl_state_e state_d;
    logic                         hit;

    assign hit = ctrl.hit_0 | ctrl.hit_1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= cache_types_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d              = state_q;
        ctrl.way_sel         = ctrl.lru;
        ctrl.data_source_sel = 1'b0;
        ctrl.tag_bypass_sel  = 1'b0;
        ctrl.load            = 1'b0;
        ctrl.load_lru        = 1'b0;

        case (state_q)
            cache_types_pkg::ST_IDLE: begin
                if (cpu_stb) begin
                    if (hit) begin
                        // write and lru update on this edge, ack next cycle
                        ctrl.way_sel  = ctrl.hit_1;
                        ctrl.load     = cpu_we;
                        ctrl.load_lru = 1'b1;
                        state_d       = cache_types_pkg::ST_RESPOND;
                    end else if (ctrl.dirty) begin
                        state_d = cache_types_pkg::ST_WRITEBACK;
                    end else begin
                        state_d = cache_types_pkg::ST_FETCH;
                    end
                end
            end

            cache_types_pkg::ST_RESPOND: begin
                // address still held, so the line still hits
                ctrl.way_sel = ctrl.hit_1;
                state_d      = cache_types_pkg::ST_IDLE;
            end

            cache_types_pkg::ST_WRITEBACK: begin
                if (mem_ack) begin
                    state_d = cache_types_pkg::ST_FETCH;
                end
            end

            cache_types_pkg::ST_FETCH: begin
                ctrl.data_source_sel = 1'b1;
                ctrl.tag_bypass_sel  = 1'b1;
                // fill the victim way, then retry as a hit from idle
                if (mem_ack) begin
                    ctrl.load = 1'b1;
                    state_d   = cache_types_pkg::ST_IDLE;
                end
            end

            default: begin
                state_d = cache_types_pkg::ST_IDLE;
            end
        endcase
    end

    assign ctrl.state = state_q;

    // bus outputs follow the state register only
    assign cpu_ack = (state_q == cache_types_pkg::ST_RESPOND);
    assign mem_we  = (state_q == cache_types_pkg::ST_WRITEBACK);
    assign mem_stb = (state_q == cache_types_pkg::ST_WRITEBACK) ||
                     (state_q == cache_types_pkg::ST_FETCH);

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_ack |=> !cpu_ack
    );

    no_mem_during_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_stb && cpu_ack)
    );

endmodule : cache_l1_control

//--- design/cache_l1.sv
`include "cache_params.svh"

module cache_l1 (
    input  logic                     clk,
    input  logic                     rst_n,

    // processor bus
    input  logic [`CACHE_ADDR_W-1:0] cpu_adr,
    input  logic [`CACHE_SEL_W-1:0]  cpu_sel,
    input  logic                     cpu_we,
    input  logic                     cpu_stb,
    input  logic [`CACHE_LINE_W-1:0] cpu_dat_m,
    output logic [`CACHE_LINE_W-1:0] cpu_dat_s,
    output logic                     cpu_ack,

    // memory bus, full lines only
    output logic [`CACHE_ADDR_W-1:0] mem_adr,
    output logic                     mem_we,
    output logic                     mem_stb,
    output logic [`CACHE_LINE_W-1:0] mem_dat_m,
    input  logic [`CACHE_LINE_W-1:0] mem_dat_s,
    input  logic                     mem_ack
);

    cache_types_pkg::cache_addr_u cpu_adr_u;
    cache_types_pkg::cache_addr_u mem_adr_u;

    // buses carry the flat address
    assign cpu_adr_u.flat = cpu_adr;
    assign mem_adr        = mem_adr_u.flat;

    cache_ctrl_if u_ctrl_if (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_l1_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (u_ctrl_if.datapath),
        .cpu_adr   (cpu_adr_u),
        .cpu_sel   (cpu_sel),
        .cpu_dat_m (cpu_dat_m),
        .mem_dat_s (mem_dat_s),
        .cpu_dat_s (cpu_dat_s),
        .mem_adr   (mem_adr_u),
        .mem_dat_m (mem_dat_m)
    );

    cache_l1_control u_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (u_ctrl_if.control),
        .cpu_stb (cpu_stb),
        .cpu_we  (cpu_we),
        .mem_ack (mem_ack),
        .cpu_ack (cpu_ack),
        .mem_stb (mem_stb),
        .mem_we  (mem_we)
    );

endmodule : cache_l1

//--- tests/cache_l1_tb.sv
`include "cache_params.svh"

module cache_l1_tb;

    localparam int ACK_TIMEOUT = 100;
    // strobe sampled at the first edge, ack seen in the cycle after
    localparam int HIT_CYCLES  = 2;
    localparam int MEM_LINES   = 1 << `CACHE_ADDR_W;

    logic                     clk;
    logic                     rst_n;
    logic [`CACHE_ADDR_W-1:0] cpu_adr;
    logic [`CACHE_SEL_W-1:0]  cpu_sel;
    logic                     cpu_we;
    logic                     cpu_stb;
    logic [`CACHE_LINE_W-1:0] cpu_dat_m;
    logic [`CACHE_LINE_W-1:0] cpu_dat_s;
    logic                     cpu_ack;
    logic [`CACHE_ADDR_W-1:0] mem_adr;
    logic                     mem_we;
    logic                     mem_stb;
    logic [`CACHE_LINE_W-1:0] mem_dat_m;
    logic [`CACHE_LINE_W-1:0] mem_dat_s;
    logic                     mem_ack;

    // backing store, one full line per address
    logic [`CACHE_LINE_W-1:0] mem [MEM_LINES];
    int                       seed = 51864;

    cache_l1 u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_we    (cpu_we),
        .cpu_stb   (cpu_stb),
        .cpu_dat_m (cpu_dat_m),
        .cpu_dat_s (cpu_dat_s),
        .cpu_ack   (cpu_ack),
        .mem_adr   (mem_adr),
        .mem_we    (mem_we),
        .mem_stb   (mem_stb),
        .mem_dat_m (mem_dat_m),
        .mem_dat_s (mem_dat_s),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("Failure at time %0t: %s", $time, what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [`CACHE_LINE_W-1:0] got,
                                 input logic [`CACHE_LINE_W-1:0] exp);
        $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Something failed");
        $fatal(1);
    endtask

    // one processor access, strobe held until ack
    task automatic cpu_access(input logic we, input logic [`CACHE_ADDR_W-1:0] adr,
                              input logic [`CACHE_SEL_W-1:0] sel,
                              input logic [`CACHE_LINE_W-1:0] wdata,
                              output int cycles, output logic saw_mem,
                              output logic [`CACHE_LINE_W-1:0] rdata);
        logic got_ack;
        got_ack = 1'b0;
        cycles  = 0;
        saw_mem = 1'b0;
        rdata   = '0;
        @(posedge clk);
        cpu_adr   <= adr;
        cpu_we    <= we;
        cpu_sel   <= sel;
        cpu_dat_m <= wdata;
        cpu_stb   <= 1'b1;
        // outputs sampled mid cycle
        while (!got_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (mem_stb) begin
                saw_mem = 1'b1;
            end
            if (cpu_ack) begin
                got_ack = 1'b1;
                rdata   = cpu_dat_s;
            end
        end
        assert (got_ack) else abort_run($sformatf("no cpu_ack for address %h", adr));
        @(posedge clk);
        cpu_stb <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    // memory model, answers each request after 0 to 3 cycles
    initial begin : memory_model
        int                       delay_left;
        logic [`CACHE_LINE_W-1:0] rd_line;
        delay_left = -1;
        rd_line    = '0;
        mem_ack   <= 1'b0;
        mem_dat_s <= '0;
        // every 16-bit slot holds the line's own address
        for (int a = 0; a < MEM_LINES; a++) begin
            mem[a] = {8{4'h0, a[`CACHE_ADDR_W-1:0]}};
        end
        forever begin
            @(negedge clk);
            if (mem_ack) begin
                @(posedge clk);
                mem_ack <= 1'b0;
            end else if (rst_n && mem_stb) begin
                if (delay_left < 0) begin
                    delay_left = $unsigned($random(seed)) % 4;
                end
                if (delay_left == 0) begin
                    delay_left = -1;
                    if (mem_we) begin
                        mem[mem_adr] = mem_dat_m;
                    end
                    rd_line = mem[mem_adr];
                    @(posedge clk);
                    mem_ack   <= 1'b1;
                    mem_dat_s <= rd_line;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    initial begin : stimulus
        int                       fd;
        int                       count;
        int                       cycles;
        string                    line;
        logic [7:0]               op;
        logic [`CACHE_ADDR_W-1:0] adr;
        logic [`CACHE_SEL_W-1:0]  sel;
        logic [`CACHE_LINE_W-1:0] wdata;
        logic [`CACHE_LINE_W-1:0] expected;
        logic [`CACHE_LINE_W-1:0] rdata;
        logic                     saw_mem;

        rst_n     <= 1'b0;
        cpu_adr   <= '0;
        cpu_sel   <= '0;
        cpu_we    <= 1'b0;
        cpu_stb   <= 1'b0;
        cpu_dat_m <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!cpu_ack && !mem_stb) else abort_run("cpu_ack or mem_stb high after reset");

        fd = $fopen("tests/cache_tests.txt", "r");
        assert (fd != 0) else abort_run("cannot open tests/cache_tests.txt");

        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%c %h %h %h %h", op, adr, sel, wdata, expected);
            assert (count == 5) else abort_run({"malformed test line: ", line});
            case (op)
                "W": begin
                    cpu_access(1'b1, adr, sel, wdata, cycles, saw_mem, rdata);
                end
                "R", "M", "H": begin
                    cpu_access(1'b0, adr, '0, '0, cycles, saw_mem, rdata);
                    assert (rdata === expected) else flag_mismatch("cpu_dat_s", rdata, expected);
                    if (op == "M") begin
                        assert (saw_mem)
                        else abort_run($sformatf("read of %h expected a miss", adr));
                    end
                    if (op == "H") begin
                        assert (!saw_mem)
                        else abort_run($sformatf("hit on %h raised mem_stb", adr));
                        assert (cycles == HIT_CYCLES)
                        else abort_run($sformatf("hit on %h took %0d cycles", adr, cycles));
                    end
                end
                "C": begin
                    assert (mem[adr] === expected)
                    else flag_mismatch($sformatf("mem[%h]", adr), mem[adr], expected);
                end
                default: begin
                    abort_run({"unknown operation in line: ", line});
                end
            endcase
        end
        $fclose(fd);

        $display("Everything OK");
        $finish;
    end

endmodule : cache_l1_tb

//--- src.f
+incdir+include
design/cache_types_pkg.sv
design/cache_ctrl_if.sv
design/cache_way.sv
design/cache_l1_datapath.sv
design/cache_l1_control.sv
design/cache_l1.sv
tests/cache_l1_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cache_l1_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cache_tests.txt
# columns: op addr sel wdata expected, all hex, unused columns are 0
# op: M read that misses, H read that hits, R read, W write, C memory line at end
# set 1, masked write then LRU eviction
M 011 0000 0 00110011001100110011001100110011
H 011 0000 0 00110011001100110011001100110011
W 011 00ff 0123456789abcdeffedcba9876543210 0
H 011 0000 0 0011001100110011fedcba9876543210
M 019 0000 0 00190019001900190019001900190019
H 011 0000 0 0011001100110011fedcba9876543210
M 021 0000 0 00210021002100210021002100210021
H 011 0000 0 0011001100110011fedcba9876543210
M 019 0000 0 00190019001900190019001900190019
# dirty 011 is the victim here
M 029 0000 0 00290029002900290029002900290029
M 011 0000 0 0011001100110011fedcba9876543210
H 029 0000 0 00290029002900290029002900290029
# set 3, write miss allocates, then dirty eviction
W 0a3 f000 0123456789abcdeffedcba9876543210 0
H 0a3 0000 0 0123456700a300a300a300a300a300a3
W 0a3 0301 11223344556677889900aabbccddeeff 0
H 0a3 0000 0 0123456700a3778800a300a300a300ff
M 0b3 0000 0 00b300b300b300b300b300b300b300b3
M 0c3 0000 0 00c300c300c300c300c300c300c300c3
H 0b3 0000 0 00b300b300b300b300b300b300b300b3
# other sets
M fff 0000 0 0fff0fff0fff0fff0fff0fff0fff0fff
H fff 0000 0 0fff0fff0fff0fff0fff0fff0fff0fff
M 7f8 0000 0 07f807f807f807f807f807f807f807f8
W 7f8 ffff a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
R 7f8 0000 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
H 7f8 0000 0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
# memory contents after the run
C 011 0000 0 0011001100110011fedcba9876543210
C 0a3 0000 0 0123456700a3778800a300a300a300ff
C 019 0000 0 00190019001900190019001900190019
C 029 0000 0 00290029002900290029002900290029
C 7f8 0000 0 07f807f807f807f807f807f807f807f8
C 123 0000 0 01230123012301230123012301230123
